// File: source/scheduler_config.svh
`ifndef SCHEDULER_CONFIG_SVH
`define SCHEDULER_CONFIG_SVH

// Hardware threads that share the issue stage
`define SCHED_THREADS 4

// Width of a register number inside the scalar file or the vector file
// The scoreboard holds both files, so it is twice as wide as one file
`define SCHED_REG_INDEX_BITS 3

// Cycles from the issue of an FP operation to its result on the FP writeback port
`define SCHED_FP_ADD_LATENCY 4

`define SCHED_FP_MUL_LATENCY 6

// The divider is the slowest unit and sets the minimum queue length
`define SCHED_FP_DIV_LATENCY 12

// Length in bits of the FP pending queue
// Must be at least as long as the largest FP latency above
`define SCHED_FP_QUEUE_DEPTH 16

`endif

// File: source/scheduler_pkg.sv
`default_nettype none

`include "scheduler_config.svh"

package scheduler_pkg;

	typedef logic [$clog2(`SCHED_THREADS)-1:0] thread_id_t;

	// One bit per hardware thread
	typedef logic [`SCHED_THREADS-1:0] thread_mask_t;

	typedef logic [`SCHED_REG_INDEX_BITS-1:0] reg_index_t;

	// A register reference is read either as its file and index, or as the bit it owns
	// in the scoreboard. Vector registers sit above the scalar ones in the flat view
	typedef union packed {
		struct packed {
			logic       is_vector;
			reg_index_t index;
		} fields;
		logic [`SCHED_REG_INDEX_BITS:0] flat;
	} reg_ref_u;

	// One busy bit per scalar and vector register of a thread
	typedef logic [2 ** (`SCHED_REG_INDEX_BITS + 1) - 1:0] scoreboard_t;

	typedef enum logic [1:0] {
		FP_NONE,
		FP_ADD,
		FP_MUL,
		FP_DIV
	} fp_class_e;

	typedef struct packed {
		logic       has_source0;
		reg_ref_u   source0;
		logic       has_source1;
		reg_ref_u   source1;
		logic       has_destination;
		reg_ref_u   destination;
		fp_class_e  fp_class;
		logic [7:0] opcode;
	} instruction_t;

	// Issue to FP writeback distance of each FP class, zero when the op is not FP
	function automatic int unsigned fp_latency(input fp_class_e fp_class);
		int unsigned latency;
		case (fp_class)
			FP_ADD:  latency = `SCHED_FP_ADD_LATENCY;
			FP_MUL:  latency = `SCHED_FP_MUL_LATENCY;
			FP_DIV:  latency = `SCHED_FP_DIV_LATENCY;
			default: latency = 0;
		endcase
		return latency;
	endfunction

endpackage

`default_nettype wire

// File: source/writeback_if.sv
`timescale 1ns/10ps
`default_nettype none

interface writeback_if;

	// One result leaving writeback, tagged with the thread that owns it
	logic                      valid;
	scheduler_pkg::thread_id_t thread_id;
	scheduler_pkg::reg_ref_u   register;

	// High when the written thread is also the one granted this cycle
	logic                      set_collide;

	modport source (
		output valid,
		output thread_id,
		output register,
		output set_collide
	);

	modport sink (
		input valid,
		input thread_id,
		input register,
		input set_collide
	);

endinterface

`default_nettype wire

// File: source/thread_scoreboard.sv
`timescale 1ns/10ps
`default_nettype none

module thread_scoreboard (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire scheduler_pkg::thread_id_t   thread_id,
	input  wire scheduler_pkg::instruction_t instruction,
	input  wire logic                        granted,
	writeback_if.sink                        wb,
	output logic                             hazard_free,
	output scheduler_pkg::scoreboard_t       destination_mask,
	output logic                             busy
);

	scheduler_pkg::scoreboard_t busy_bits;
	scheduler_pkg::scoreboard_t source_mask;
	scheduler_pkg::scoreboard_t set_mask;
	scheduler_pkg::scoreboard_t clear_mask;
	logic                       wb_hit;

	// Both source operands share one mask, since either of them alone is a RAW hazard
	always_comb begin
		source_mask = '0;
		destination_mask = '0;
		if (instruction.has_source0) begin
			source_mask[instruction.source0.flat] = 1'b1;
		end
		if (instruction.has_source1) begin
			source_mask[instruction.source1.flat] = 1'b1;
		end
		if (instruction.has_destination) begin
			destination_mask[instruction.destination.flat] = 1'b1;
		end
	end

	// A busy source is a RAW hazard and a busy destination a WAW hazard
	assign hazard_free = ~|((source_mask | destination_mask) & busy_bits);

	assign set_mask = granted ? destination_mask : '0;

	// Only results of this thread free registers here
	assign wb_hit = wb.valid && (wb.thread_id == thread_id);

	always_comb begin
		clear_mask = '0;
		if (wb_hit) begin
			clear_mask[wb.register.flat] = 1'b1;
		end
		// A result that lands on the register being reserved this cycle leaves it busy
		if (wb.set_collide) begin
			clear_mask = clear_mask & ~set_mask;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy_bits <= '0;
		end else begin
			busy_bits <= (busy_bits | set_mask) & ~clear_mask;
		end
	end

	assign busy = |busy_bits;

	// The arbiter must only grant this thread when its destination is free
	set_on_free_bit: assert property (
		@(posedge clk) disable iff (reset)
		granted |-> ((set_mask & busy_bits) == '0)
	) else $error("thread %0d reserved a register that is already busy", thread_id);

endmodule

`default_nettype wire

// File: source/fp_port_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "scheduler_config.svh"

module fp_port_tracker (
	input  wire logic                                              clk,
	input  wire logic                                              reset,
	input  wire scheduler_pkg::instruction_t [`SCHED_THREADS-1:0] instruction,
	input  wire logic                                              grant_valid,
	input  wire scheduler_pkg::thread_id_t                         grant_id,
	output scheduler_pkg::thread_mask_t                            fp_clear
);

	typedef logic [`SCHED_FP_QUEUE_DEPTH-1:0] fp_queue_t;

	// Bit k set means an FP result reaches the writeback port k+1 cycles from now
	fp_queue_t pending_queue;
	fp_queue_t reserve_mask;
	fp_queue_t queue_next;

	// Queue slot that an op of the given class would occupy if issued this cycle
	function automatic fp_queue_t slot_of(input scheduler_pkg::fp_class_e fp_class);
		fp_queue_t slot;
		slot = '0;
		if (fp_class != scheduler_pkg::FP_NONE) begin
			slot[scheduler_pkg::fp_latency(fp_class) - 1] = 1'b1;
		end
		return slot;
	endfunction

	// Integer ops never touch the FP port, so their slot is empty and they always pass
	always_comb begin
		for (int t = 0; t < `SCHED_THREADS; t++) begin
			fp_clear[t] = ~|(slot_of(instruction[t].fp_class) & pending_queue);
		end
	end

	assign reserve_mask = grant_valid ? slot_of(instruction[grant_id].fp_class) : '0;

	// The reservation enters at its latency minus one and then ages with the rest,
	// so that next cycle it is one step closer to the port
	assign queue_next = (pending_queue | reserve_mask) >> 1;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending_queue <= '0;
		end else begin
			pending_queue <= queue_next;
		end
	end

	// A granted FP op must have found its writeback cycle free
	reserved_slot_free: assert property (
		@(posedge clk) disable iff (reset)
		grant_valid |-> ((reserve_mask & pending_queue) == '0)
	) else $error("FP result of thread %0d collides on the writeback port", grant_id);

endmodule

`default_nettype wire

// File: source/issue_select.sv
`timescale 1ns/10ps
`default_nettype none

`include "scheduler_config.svh"

module issue_select (
	input  wire logic                                              clk,
	input  wire logic                                              reset,
	input  wire scheduler_pkg::thread_mask_t                       eligible,
	input  wire scheduler_pkg::instruction_t [`SCHED_THREADS-1:0] instruction,
	input  wire scheduler_pkg::scoreboard_t  [`SCHED_THREADS-1:0] destination_mask,
	output scheduler_pkg::thread_mask_t                            grant_mask,
	output scheduler_pkg::thread_id_t                              grant_id,
	output logic                                                   issue_valid,
	output scheduler_pkg::thread_id_t                              issue_thread_id,
	output scheduler_pkg::instruction_t                            issue_instruction,
	output scheduler_pkg::scoreboard_t                             issue_destination_mask
);

	// Thread with the highest priority this cycle
	scheduler_pkg::thread_id_t first_priority;
	logic                      grant_found;

	// Search the eligible threads starting from the one with the highest priority
	always_comb begin
		int candidate;
		grant_mask = '0;
		grant_id = '0;
		grant_found = 1'b0;
		for (int offset = 0; offset < `SCHED_THREADS; offset++) begin
			candidate = (int'(first_priority) + offset) % `SCHED_THREADS;
			if (!grant_found && eligible[candidate]) begin
				grant_found = 1'b1;
				grant_mask[candidate] = 1'b1;
				grant_id = scheduler_pkg::thread_id_t'(candidate);
			end
		end
	end

	// The thread just granted drops to the lowest priority
	// Without a grant the order stays as it is
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			first_priority <= '0;
		end else if (grant_found) begin
			first_priority <= scheduler_pkg::thread_id_t'((int'(grant_id) + 1) % `SCHED_THREADS);
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			issue_valid <= 1'b0;
		end else begin
			issue_valid <= grant_found;
		end
	end

	// Operand fetch only looks at these while issue_valid is high
	always_ff @(posedge clk) begin
		if (grant_found) begin
			issue_thread_id <= grant_id;
			issue_instruction <= instruction[grant_id];
			issue_destination_mask <= destination_mask[grant_id];
		end
	end

	grant_one_hot: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0(grant_mask)
	) else $error("more than one thread granted, grant_mask %b", grant_mask);

endmodule

`default_nettype wire

// File: source/instruction_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

`include "scheduler_config.svh"

module instruction_scheduler (
	input  wire logic                                              clk,
	input  wire logic                                              reset,

	// Instruction buffer
	input  wire scheduler_pkg::thread_mask_t                       ib_valid,
	input  wire scheduler_pkg::instruction_t [`SCHED_THREADS-1:0] ib_instruction,

	// Writeback
	input  wire logic                                              wb_valid,
	input  wire scheduler_pkg::thread_id_t                         wb_thread_id,
	input  wire scheduler_pkg::reg_ref_u                           wb_register,
	input  wire logic                                              wb_stall,

	// Grant back to the instruction buffer
	output scheduler_pkg::thread_mask_t                            issue_thread_mask,

	// Operand fetch
	output logic                                                   issue_valid,
	output scheduler_pkg::thread_id_t                              issue_thread_id,
	output scheduler_pkg::instruction_t                            issue_instruction,
	output scheduler_pkg::scoreboard_t                             issue_destination_mask,

	output scheduler_pkg::thread_mask_t                            scoreboard_busy
);

	scheduler_pkg::thread_mask_t                       hazard_free;
	scheduler_pkg::thread_mask_t                       fp_clear;
	scheduler_pkg::thread_mask_t                       eligible;
	scheduler_pkg::thread_mask_t                       grant_mask;
	scheduler_pkg::thread_id_t                         grant_id;
	scheduler_pkg::scoreboard_t  [`SCHED_THREADS-1:0] destination_mask;

	writeback_if wb_bus ();

	assign wb_bus.valid = wb_valid;
	assign wb_bus.thread_id = wb_thread_id;
	assign wb_bus.register = wb_register;
	assign wb_bus.set_collide = wb_valid && grant_mask[wb_thread_id];

	// A full writeback path holds every thread back
	assign eligible = ib_valid & hazard_free & fp_clear & {`SCHED_THREADS{~wb_stall}};

	generate
		for (genvar t = 0; t < `SCHED_THREADS; t++) begin : g_scoreboard
			thread_scoreboard u_scoreboard (
				.clk              (clk),
				.reset            (reset),
				.thread_id        (scheduler_pkg::thread_id_t'(t)),
				.instruction      (ib_instruction[t]),
				.granted          (grant_mask[t]),
				.wb               (wb_bus.sink),
				.hazard_free      (hazard_free[t]),
				.destination_mask (destination_mask[t]),
				.busy             (scoreboard_busy[t])
			);
		end
	endgenerate

	fp_port_tracker u_fp_port_tracker (
		.clk         (clk),
		.reset       (reset),
		.instruction (ib_instruction),
		.grant_valid (|grant_mask),
		.grant_id    (grant_id),
		.fp_clear    (fp_clear)
	);

	issue_select u_issue_select (
		.clk                    (clk),
		.reset                  (reset),
		.eligible               (eligible),
		.instruction            (ib_instruction),
		.destination_mask       (destination_mask),
		.grant_mask             (grant_mask),
		.grant_id               (grant_id),
		.issue_valid            (issue_valid),
		.issue_thread_id        (issue_thread_id),
		.issue_instruction      (issue_instruction),
		.issue_destination_mask (issue_destination_mask)
	);

	assign issue_thread_mask = grant_mask;

endmodule

`default_nettype wire

// File: test/tb_instruction_scheduler.sv
`timescale 1ns/10ps
`default_nettype none

`include "scheduler_config.svh"

module tb_instruction_scheduler;

	typedef struct packed {
		scheduler_pkg::instruction_t [3:0] ins;
		scheduler_pkg::thread_mask_t       valid;
		logic                              wbv;
		scheduler_pkg::thread_id_t         wbt;
		logic [3:0]                        wbr;
		logic                              stall;
		logic                              check_grant;
		scheduler_pkg::thread_mask_t       exp_grant;
	} row_t;

	logic clk = 1'b0;
	logic reset = 1'b1;
	scheduler_pkg::thread_mask_t                       ib_valid;
	scheduler_pkg::instruction_t [`SCHED_THREADS-1:0] ib_instruction;
	logic                                              wb_valid;
	scheduler_pkg::thread_id_t                         wb_thread_id;
	scheduler_pkg::reg_ref_u                           wb_register;
	logic                                              wb_stall;
	scheduler_pkg::thread_mask_t                       issue_thread_mask;
	logic                                              issue_valid;
	scheduler_pkg::thread_id_t                         issue_thread_id;
	scheduler_pkg::instruction_t                       issue_instruction;
	scheduler_pkg::scoreboard_t                        issue_destination_mask;
	scheduler_pkg::thread_mask_t                       scoreboard_busy;

	row_t table_rows[$];
	int mismatch_count = 0;
	int failure_count = 0;
	int cycle = 0;
	int fp_done[$];
	logic [15:0] lfsr = 16'd67;

	// Reference model state
	scheduler_pkg::scoreboard_t  model_sb[4];
	logic [15:0]                 model_queue = '0;
	int                          model_rr = 0;
	logic                        exp_valid = 1'b0;
	scheduler_pkg::thread_id_t   exp_tid;
	scheduler_pkg::instruction_t exp_ins;
	scheduler_pkg::scoreboard_t  exp_dmask;
	scheduler_pkg::thread_mask_t exp_busy = '0;

	instruction_scheduler u_dut (
		.clk                    (clk),
		.reset                  (reset),
		.ib_valid               (ib_valid),
		.ib_instruction         (ib_instruction),
		.wb_valid               (wb_valid),
		.wb_thread_id           (wb_thread_id),
		.wb_register            (wb_register),
		.wb_stall               (wb_stall),
		.issue_thread_mask      (issue_thread_mask),
		.issue_valid            (issue_valid),
		.issue_thread_id        (issue_thread_id),
		.issue_instruction      (issue_instruction),
		.issue_destination_mask (issue_destination_mask),
		.scoreboard_busy        (scoreboard_busy)
	);

	always #5 clk = ~clk;

	// Fibonacci LFSR with taps 16, 14, 13 and 11
	function automatic logic take_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [15:0] random_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], take_bit()};
		end
		return v;
	endfunction

	function automatic int class_latency(input scheduler_pkg::fp_class_e c);
		if (c == scheduler_pkg::FP_ADD) return `SCHED_FP_ADD_LATENCY;
		if (c == scheduler_pkg::FP_MUL) return `SCHED_FP_MUL_LATENCY;
		if (c == scheduler_pkg::FP_DIV) return `SCHED_FP_DIV_LATENCY;
		return 0;
	endfunction

	function automatic scheduler_pkg::instruction_t make_instr(
			input logic hs0, input logic [3:0] s0,
			input logic hs1, input logic [3:0] s1, input logic hd, input logic [3:0] d,
			input scheduler_pkg::fp_class_e c, input logic [7:0] op);
		scheduler_pkg::instruction_t ins;
		ins.has_source0 = hs0;
		ins.source0.flat = s0;
		ins.has_source1 = hs1;
		ins.source1.flat = s1;
		ins.has_destination = hd;
		ins.destination.flat = d;
		ins.fp_class = c;
		ins.opcode = op;
		return ins;
	endfunction

	task automatic report_mismatch(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		mismatch_count++;
	endtask

	// Registered outputs are compared on the falling edge, half a cycle after they change
	task automatic check_registered();
		if (issue_valid !== exp_valid)
			report_mismatch("issue_valid", 64'(exp_valid), 64'(issue_valid));
		if (exp_valid) begin
			if (issue_thread_id !== exp_tid)
				report_mismatch("issue_thread_id", 64'(exp_tid), 64'(issue_thread_id));
			if (issue_instruction !== exp_ins)
				report_mismatch("issue_instruction", 64'(exp_ins), 64'(issue_instruction));
			if (issue_destination_mask !== exp_dmask)
				report_mismatch("issue_destination_mask", 64'(exp_dmask),
					64'(issue_destination_mask));
		end
		if (scoreboard_busy !== exp_busy)
			report_mismatch("scoreboard_busy", 64'(exp_busy), 64'(scoreboard_busy));
	endtask

	task automatic apply_cycle(input row_t r);
		scheduler_pkg::thread_mask_t eligible;
		scheduler_pkg::scoreboard_t  mask;
		scheduler_pkg::instruction_t ins;
		logic [15:0] reserve;
		logic found;
		int g;
		int c;
		int lat;
		@(negedge clk);
		check_registered();
		ib_valid = r.valid;
		ib_instruction = r.ins;
		wb_valid = r.wbv;
		wb_thread_id = r.wbt;
		wb_register.flat = r.wbr;
		wb_stall = r.stall;
		#1;
		for (int t = 0; t < 4; t++) begin
			ins = r.ins[t];
			mask = '0;
			if (ins.has_source0) mask[ins.source0.flat] = 1'b1;
			if (ins.has_source1) mask[ins.source1.flat] = 1'b1;
			if (ins.has_destination) mask[ins.destination.flat] = 1'b1;
			lat = class_latency(ins.fp_class);
			eligible[t] = r.valid[t] && !r.stall && ((mask & model_sb[t]) == '0)
				&& (lat == 0 || !model_queue[lat-1]);
		end
		found = 1'b0;
		g = 0;
		for (int off = 0; off < 4; off++) begin
			c = (model_rr + off) % 4;
			if (!found && eligible[c]) begin
				found = 1'b1;
				g = c;
			end
		end
		if (issue_thread_mask !== (found ? 4'(1 << g) : 4'b0000))
			report_mismatch("issue_thread_mask", 64'(found ? 1 << g : 0),
				64'(issue_thread_mask));
		if (r.check_grant && issue_thread_mask !== r.exp_grant)
			report_mismatch("issue_thread_mask (table)", 64'(r.exp_grant),
				64'(issue_thread_mask));
		// Completion cycles of the FP ops that the DUT granted
		for (int t = 0; t < 4; t++) begin
			ins = r.ins[t];
			lat = class_latency(ins.fp_class);
			if (issue_thread_mask[t] && lat != 0) begin
				foreach (fp_done[i]) begin
					if (fp_done[i] == cycle + lat) begin
						$display("FP result of thread %0d at %0t lands on an occupied port cycle",
							t, $time);
						failure_count++;
					end
				end
				fp_done.push_back(cycle + lat);
			end
		end
		// A writeback frees its bit first and a new reservation then wins
		if (r.wbv) model_sb[r.wbt][r.wbr] = 1'b0;
		reserve = '0;
		exp_valid = found;
		if (found) begin
			ins = r.ins[g];
			exp_tid = 2'(g);
			exp_ins = ins;
			exp_dmask = '0;
			if (ins.has_destination) begin
				exp_dmask[ins.destination.flat] = 1'b1;
				model_sb[g][ins.destination.flat] = 1'b1;
			end
			lat = class_latency(ins.fp_class);
			if (lat != 0) begin
				reserve[lat-1] = 1'b1;
			end
			model_rr = (g + 1) % 4;
		end
		model_queue = (model_queue | reserve) >> 1;
		for (int t = 0; t < 4; t++) exp_busy[t] = |model_sb[t];
		cycle++;
	endtask

	task automatic add_row(input scheduler_pkg::instruction_t i0,
			input scheduler_pkg::instruction_t i1,
			input scheduler_pkg::instruction_t i2, input scheduler_pkg::instruction_t i3,
			input logic [3:0] valid, input logic wbv, input logic [1:0] wbt, input logic [3:0] wbr,
			input logic stall, input logic [3:0] exp_grant);
		row_t r;
		r.ins = {i3, i2, i1, i0};
		r.valid = valid;
		r.wbv = wbv;
		r.wbt = wbt;
		r.wbr = wbr;
		r.stall = stall;
		r.check_grant = 1'b1;
		r.exp_grant = exp_grant;
		table_rows.push_back(r);
	endtask

	initial begin
		scheduler_pkg::instruction_t nop;
		scheduler_pkg::instruction_t d_s1;
		scheduler_pkg::instruction_t d_s2;
		scheduler_pkg::instruction_t d_v1;
		scheduler_pkg::instruction_t r_s1;
		scheduler_pkg::instruction_t r_v1;
		scheduler_pkg::instruction_t f_add;
		scheduler_pkg::instruction_t f_mul;
		scheduler_pkg::instruction_t f_div;
		row_t r;
		int waited;
		ib_valid = '0;
		ib_instruction = '0;
		wb_valid = 1'b0;
		wb_thread_id = '0;
		wb_register = '0;
		wb_stall = 1'b0;
		for (int t = 0; t < 4; t++) model_sb[t] = '0;
		nop = make_instr(0, 0, 0, 0, 0, 0, scheduler_pkg::FP_NONE, 8'h00);
		d_s1 = make_instr(0, 0, 0, 0, 1, 4'd1, scheduler_pkg::FP_NONE, 8'h10);
		d_s2 = make_instr(0, 0, 0, 0, 1, 4'd2, scheduler_pkg::FP_NONE, 8'h11);
		d_v1 = make_instr(0, 0, 0, 0, 1, 4'd9, scheduler_pkg::FP_NONE, 8'h12);
		r_s1 = make_instr(1, 4'd1, 0, 0, 0, 0, scheduler_pkg::FP_NONE, 8'h20);
		r_v1 = make_instr(1, 4'd9, 0, 0, 0, 0, scheduler_pkg::FP_NONE, 8'h21);
		f_add = make_instr(0, 0, 0, 0, 0, 0, scheduler_pkg::FP_ADD, 8'h30);
		f_mul = make_instr(0, 0, 0, 0, 0, 0, scheduler_pkg::FP_MUL, 8'h31);
		f_div = make_instr(0, 0, 0, 0, 0, 0, scheduler_pkg::FP_DIV, 8'h32);
		// Round robin, then RAW and WAW on scalar and vector registers
		add_row(d_s1, d_s1, d_v1, d_s2, 4'b1111, 0, 0, 0, 0, 4'b0001);
		add_row(r_s1, d_s1, d_v1, d_s2, 4'b1111, 0, 0, 0, 0, 4'b0010);
		add_row(r_s1, r_v1, d_v1, d_s2, 4'b1111, 0, 0, 0, 0, 4'b0100);
		add_row(r_s1, r_v1, d_v1, d_s2, 4'b1111, 0, 0, 0, 0, 4'b1000);
		add_row(r_s1, r_v1, d_v1, nop, 4'b1111, 0, 0, 0, 1, 4'b0000);
		add_row(r_s1, r_v1, d_v1, nop, 4'b1111, 1, 0, 4'd1, 0, 4'b0010);
		add_row(r_s1, nop, d_v1, nop, 4'b1111, 0, 0, 0, 0, 4'b1000);
		add_row(r_s1, nop, d_v1, nop, 4'b1111, 1, 2, 4'd9, 0, 4'b0001);
		add_row(nop, nop, d_v1, nop, 4'b1110, 0, 0, 0, 0, 4'b0010);
		add_row(nop, nop, d_v1, nop, 4'b0100, 0, 0, 0, 0, 4'b0100);
		// FP port collisions between divide, multiply and add
		add_row(f_div, nop, nop, nop, 4'b0001, 0, 0, 0, 0, 4'b0001);
		add_row(nop, f_add, nop, nop, 4'b0010, 0, 0, 0, 0, 4'b0010);
		add_row(nop, nop, f_mul, nop, 4'b0100, 0, 0, 0, 0, 4'b0100);
		add_row(nop, nop, nop, nop, 4'b0000, 0, 0, 0, 0, 4'b0000);
		add_row(nop, nop, nop, f_add, 4'b1010, 0, 0, 0, 0, 4'b0010);
		add_row(nop, nop, nop, f_add, 4'b1000, 0, 0, 0, 0, 4'b1000);
		// A reservation and a writeback of the same register in one cycle keep it busy
		add_row(d_s1, nop, nop, nop, 4'b0001, 1, 0, 4'd1, 0, 4'b0001);
		add_row(nop, nop, nop, nop, 4'b0000, 1, 0, 4'd1, 0, 4'b0000);
		add_row(nop, nop, nop, nop, 4'b0000, 1, 1, 4'd1, 0, 4'b0000);
		add_row(nop, nop, nop, nop, 4'b0000, 1, 2, 4'd9, 0, 4'b0000);
		add_row(nop, nop, nop, nop, 4'b0000, 1, 3, 4'd2, 0, 4'b0000);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (table_rows[i]) apply_cycle(table_rows[i]);
		// Let the pipeline drain and every scoreboard empty
		r = table_rows[table_rows.size()-1];
		r.wbv = 1'b0;
		r.check_grant = 1'b0;
		waited = 0;
		while ((issue_valid || scoreboard_busy != '0) && waited < 20) begin
			apply_cycle(r);
			waited++;
		end
		if (waited >= 20) begin
			$display("Timed out waiting for the scheduler to go idle");
			failure_count++;
		end
		// Free run with random instructions, writebacks and stalls
		for (int n = 0; n < 300; n++) begin
			for (int t = 0; t < 4; t++) begin
				r.ins[t] = make_instr(take_bit(), 4'(random_bits(4)), take_bit(),
					4'(random_bits(4)), take_bit(), 4'(random_bits(4)),
					scheduler_pkg::fp_class_e'(random_bits(2)), 8'(random_bits(8)));
			end
			r.valid = 4'(random_bits(4));
			r.wbv = take_bit();
			r.wbt = 2'(random_bits(2));
			r.wbr = 4'(random_bits(4));
			r.stall = (random_bits(3) == 16'd7);
			r.check_grant = 1'b0;
			apply_cycle(r);
		end
		@(negedge clk);
		check_registered();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
source/scheduler_pkg.sv
source/writeback_if.sv
source/thread_scoreboard.sv
source/fp_port_tracker.sv
source/issue_select.sv
source/instruction_scheduler.sv
test/tb_instruction_scheduler.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the instruction scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_instruction_scheduler \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_instruction_scheduler)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^>>> PASS$"; then
	exit 0
fi
exit 1
